// File: verilog/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // slave count and RAM depth
  localparam int unsigned NUM_SLAVES = 4;
  localparam int unsigned RAM_WORDS  = 256;

  localparam int unsigned SLV_IDX_W  = $clog2(NUM_SLAVES);
  localparam int unsigned WORD_IDX_W = $clog2(RAM_WORDS);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  // bit k enables byte k, byte 0 is the lsb
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [SLV_IDX_W-1:0]  slave_idx_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  // address map
  localparam int unsigned SLAVE_SPAN_BYTES = 1024;
  localparam addr_t       MAP_BASE         = 32'h0000_0000;
  localparam addr_t       MAP_END          = 32'h0000_0FFF;

  // field positions inside a window offset
  localparam int unsigned WORD_LSB = $clog2(BE_W);
  localparam int unsigned SLV_LSB  = $clog2(SLAVE_SPAN_BYTES);

  // returned with an error response
  localparam data_t ERR_RDATA = 32'h0000_0000;

endpackage

`default_nettype wire

// File: verilog/slave_bus_if.sv
`default_nettype none

interface slave_bus_if import soc_bus_pkg::*; ();

  // request, driven by the decoder
  logic      stb;
  logic      we;
  word_idx_t widx;
  data_t     wdata;
  be_t       be;

  // response, driven by the RAM
  data_t     rdata;
  logic      ack;

  modport master (
    output stb, we, widx, wdata, be,
    input  rdata, ack
  );

  modport slave (
    input  stb, we, widx, wdata, be,
    output rdata, ack
  );

  // response side only looks
  modport monitor (
    input stb, we, widx, wdata, be, rdata, ack
  );

endinterface

`default_nettype wire

// File: verilog/addr_decoder.sv
`default_nettype none

module addr_decoder import soc_bus_pkg::*; (
  input  wire         sysclock,
  input  wire         rst_n,
  input  wire         req_valid_i,
  input  wire         req_we_i,
  input  addr_t       req_addr_i,
  input  data_t       req_wdata_i,
  input  be_t         req_be_i,
  input  wire         rsp_valid_i,
  output logic        req_ready_o,
  output logic        err_pulse_o,
  output logic        we_o,
  slave_bus_if.master slv_o [NUM_SLAVES]
);

  logic                  busy_q;
  logic                  accept;
  logic                  in_map;
  addr_t                 offset;
  slave_idx_t            slv_idx;
  word_idx_t             word_idx;
  logic [NUM_SLAVES-1:0] stb_q;
  logic                  err_q;
  logic                  we_q;
  word_idx_t             widx_q;
  data_t                 wdata_q;
  be_t                   be_q;

  // one transaction in flight
  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & ~busy_q;

  // window check and field split
  assign offset   = req_addr_i - MAP_BASE;
  assign in_map   = (offset <= (MAP_END - MAP_BASE));
  assign slv_idx  = offset[SLV_LSB +: SLV_IDX_W];
  assign word_idx = offset[WORD_LSB +: WORD_IDX_W];

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      stb_q  <= '0;
      err_q  <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      // strobe and error only last one cycle
      stb_q <= '0;
      err_q <= accept & ~in_map;
      if (accept) begin
        busy_q <= 1'b1;
        we_q   <= req_we_i;
        if (in_map) begin
          stb_q[slv_idx] <= 1'b1;
        end
      end else if (rsp_valid_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // request payload
  always_ff @(posedge sysclock) begin
    if (accept) begin
      widx_q  <= word_idx;
      wdata_q <= req_wdata_i;
      be_q    <= req_be_i;
    end
  end

  assign err_pulse_o = err_q;
  assign we_o        = we_q;

  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_slv
    assign slv_o[g].stb   = stb_q[g];
    assign slv_o[g].we    = we_q;
    assign slv_o[g].widx  = widx_q;
    assign slv_o[g].wdata = wdata_q;
    assign slv_o[g].be    = be_q;
  end

endmodule

`default_nettype wire

// File: verilog/scratch_ram.sv
`default_nettype none

module scratch_ram import soc_bus_pkg::*; (
  input  wire        sysclock,
  input  wire        rst_n,
  slave_bus_if.slave bus_i
);

  data_t mem [RAM_WORDS];
  data_t rdata_q;
  logic  ack_q;
  logic  wr_en;
  logic  rd_en;

  assign wr_en = bus_i.stb & bus_i.we;
  assign rd_en = bus_i.stb & ~bus_i.we;

  // byte lanes, only enabled ones change
  always_ff @(posedge sysclock) begin
    if (wr_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bus_i.be[b]) begin
          mem[bus_i.widx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // read word, held through writes
  always_ff @(posedge sysclock) begin
    if (rd_en) begin
      rdata_q <= mem[bus_i.widx];
    end
  end

  // ack one cycle after the strobe
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_i.stb;
    end
  end

  assign bus_i.rdata = rdata_q;
  assign bus_i.ack   = ack_q;

endmodule

`default_nettype wire

// File: verilog/resp_collector.sv
`default_nettype none

module resp_collector import soc_bus_pkg::*; (
  input  wire          sysclock,
  input  wire          rst_n,
  input  wire          err_pulse_i,
  input  wire          we_i,
  slave_bus_if.monitor slv_i [NUM_SLAVES],
  output logic         rsp_valid_o,
  output data_t        rsp_rdata_o,
  output logic         rsp_err_o
);

  logic [NUM_SLAVES-1:0] ack_vec;
  data_t                 gated [NUM_SLAVES];
  data_t                 rdata_or;

  // pull each slave out of the interface array
  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_tap
    assign ack_vec[g] = slv_i[g].ack;
    assign gated[g]   = slv_i[g].ack ? slv_i[g].rdata : '0;
  end

  // read data or-tree
  always_comb begin
    rdata_or = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      rdata_or = rdata_or | gated[i];
    end
  end

  assign rsp_valid_o = (|ack_vec) | err_pulse_i;
  assign rsp_err_o   = err_pulse_i;

  // error wins, then writes return zero
  always_comb begin
    if (err_pulse_i) begin
      rsp_rdata_o = ERR_RDATA;
    end else if (we_i) begin
      rsp_rdata_o = '0;
    end else begin
      rsp_rdata_o = rdata_or;
    end
  end

endmodule

`default_nettype wire

// File: verilog/bus_fabric_top.sv
`default_nettype none

module bus_fabric_top import soc_bus_pkg::*; (
  input  wire   sysclock,
  input  wire   rst_n,
  // host request
  input  wire   req_valid_i,
  input  wire   req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  be_t   req_be_i,
  output logic  req_ready_o,
  // host response
  output logic  rsp_valid_o,
  output data_t rsp_rdata_o,
  output logic  rsp_err_o
);

  slave_bus_if slv_bus [NUM_SLAVES] ();

  logic err_pulse;
  logic dec_we;
  logic rsp_valid;

  addr_decoder u_addr_decoder (
    .sysclock    (sysclock),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .rsp_valid_i (rsp_valid),
    .req_ready_o (req_ready_o),
    .err_pulse_o (err_pulse),
    .we_o        (dec_we),
    .slv_o       (slv_bus)
  );

  // one scratch RAM per slot in the map
  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_ram
    scratch_ram u_scratch_ram (
      .sysclock (sysclock),
      .rst_n    (rst_n),
      .bus_i    (slv_bus[g])
    );
  end

  resp_collector u_resp_collector (
    .sysclock    (sysclock),
    .rst_n       (rst_n),
    .err_pulse_i (err_pulse),
    .we_i        (dec_we),
    .slv_i       (slv_bus),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
  );

  assign rsp_valid_o = rsp_valid;

endmodule

`default_nettype wire

// File: tests/tb_bus_fabric.sv
`default_nettype none

module tb_bus_fabric import soc_bus_pkg::*; ();

  localparam int    CLK_PERIOD     = 4;
  localparam int    RST_CYCLES     = 2;
  localparam int    CYCLES_PER_PAT = 10;
  localparam int    WAIT_LIMIT     = 8;
  localparam string PAT_FILE       = "tests/bus_patterns.txt";

  logic  sysclock;
  logic  rst_n;
  logic  req_valid;
  logic  req_we;
  addr_t req_addr;
  data_t req_wdata;
  be_t   req_be;
  logic  req_ready;
  logic  rsp_valid;
  data_t rsp_rdata;
  logic  rsp_err;

  // one entry per pattern line
  string pat_name [$];
  logic  pat_we [$];
  addr_t pat_addr [$];
  data_t pat_wdata [$];
  be_t   pat_be [$];
  data_t pat_exp_rdata [$];
  logic  pat_exp_err [$];

  int   data_errs;
  int   err_errs;
  int   lat_errs;
  int   proto_errs;
  logic loaded;

  bus_fabric_top dut_i (
    .sysclock    (sysclock),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_be_i    (req_be),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err)
  );

  initial begin
    sysclock = 1'b0;
    forever #(CLK_PERIOD / 2) sysclock = ~sysclock;
  end

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       line;
    string       name;
    string       op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] be;
    logic [31:0] rdata;
    logic [31:0] err;
    fd = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      $display("could not open pattern file %s", PAT_FILE);
      proto_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, wdata, be, rdata, err);
      // blank lines scan nothing
      if (cnt <= 0) begin
        continue;
      end
      if (cnt != 7 || (op != "W" && op != "R")) begin
        $display("malformed pattern line: %s", line);
        proto_errs++;
      end else begin
        pat_name.push_back(name);
        pat_we.push_back(op == "W");
        pat_addr.push_back(addr);
        pat_wdata.push_back(wdata);
        pat_be.push_back(be[BE_W-1:0]);
        pat_exp_rdata.push_back(rdata);
        pat_exp_err.push_back(err[0]);
      end
    end
    $fclose(fd);
  endtask

  // mapped only when every bit above 11 is zero
  function automatic int expected_latency(input addr_t addr);
    return (addr[31:12] == '0) ? 2 : 1;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s rdata expected %h actual %h", name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s err expected %b actual %b", name, exp, act);
      err_errs++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s latency expected %0d actual %0d", name, exp, act);
      lat_errs++;
    end
  endtask

  task automatic run_transaction(input int idx);
    int    gap;
    int    waited;
    int    lat;
    string name;
    name = pat_name[idx];
    // b2b lines go out with no idle gap
    if (name.substr(0, 2) == "b2b") begin
      gap = 0;
    end else begin
      gap = int'($urandom % 4);
    end
    repeat (gap) @(negedge sysclock);
    req_valid = 1'b1;
    req_we    = pat_we[idx];
    req_addr  = pat_addr[idx];
    req_wdata = pat_wdata[idx];
    req_be    = pat_be[idx];
    // ready seen here means the next rising edge accepts
    waited = 0;
    while (!req_ready && waited < WAIT_LIMIT) begin
      @(negedge sysclock);
      waited++;
    end
    if (!req_ready) begin
      $display("%s: request never accepted, req_ready_o stayed low", name);
      proto_errs++;
      req_valid = 1'b0;
      return;
    end
    lat = 0;
    do begin
      @(negedge sysclock);
      lat++;
      if (lat == 1) begin
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_be    = '0;
      end
      if (req_ready) begin
        $display("%s: req_ready_o high %0d cycles after acceptance", name, lat);
        proto_errs++;
      end
    end while (!rsp_valid && lat < WAIT_LIMIT);
    if (!rsp_valid) begin
      $display("%s: no response within %0d cycles", name, WAIT_LIMIT);
      proto_errs++;
      return;
    end
    check_latency(name, expected_latency(pat_addr[idx]), lat);
    check_data(name, pat_exp_rdata[idx], rsp_rdata);
    check_err(name, pat_exp_err[idx], rsp_err);
    @(negedge sysclock);
    if (!req_ready) begin
      $display("%s: req_ready_o did not return high after the response", name);
      proto_errs++;
    end
    if (rsp_valid) begin
      $display("%s: rsp_valid_o lasted more than one cycle", name);
      proto_errs++;
    end
  endtask

  initial begin
    int total;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    req_be     = '0;
    data_errs  = 0;
    err_errs   = 0;
    lat_errs   = 0;
    proto_errs = 0;
    loaded     = 1'b0;
    void'($urandom(65269));
    load_patterns();
    if (pat_name.size() == 0) begin
      $display("no patterns were loaded");
      proto_errs++;
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(negedge sysclock);
    rst_n = 1'b1;
    @(negedge sysclock);
    if (!req_ready || rsp_valid) begin
      $display("wrong state after reset, ready %b valid %b", req_ready, rsp_valid);
      proto_errs++;
    end
    for (int i = 0; i < pat_name.size(); i++) begin
      run_transaction(i);
    end
    total = data_errs + err_errs + lat_errs + proto_errs;
    $display("errors: data %0d, err flag %0d, latency %0d, protocol %0d",
             data_errs, err_errs, lat_errs, proto_errs);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    int limit_cycles;
    wait (loaded);
    limit_cycles = pat_name.size() * CYCLES_PER_PAT + RST_CYCLES + 4;
    #(limit_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/soc_bus_pkg.sv
verilog/slave_bus_if.sv
verilog/addr_decoder.sv
verilog/scratch_ram.sv
verilog/resp_collector.sv
verilog/bus_fabric_top.sv
tests/tb_bus_fabric.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_bus_fabric
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/bus_patterns.txt
# name op(W/R) addr wdata be exp_rdata exp_err, all numbers in hex
# writes and error responses expect zero read data
wr_s0_full     W 00000010 11223344 f 00000000 0
rd_s0_full     R 00000010 00000000 f 11223344 0
wr_s1_full     W 00000410 55667788 f 00000000 0
rd_s1_full     R 00000410 00000000 f 55667788 0
wr_s2_full     W 00000810 99aabbcc f 00000000 0
rd_s2_full     R 00000810 00000000 f 99aabbcc 0
wr_s3_full     W 00000c10 ddeeff00 f 00000000 0
rd_s3_full     R 00000c10 00000000 f ddeeff00 0
# same word index, independent slaves
rd_s0_indep    R 00000010 00000000 f 11223344 0
rd_s1_indep    R 00000410 00000000 f 55667788 0
# low address bits ignored
rd_s2_alias1   R 00000811 00000000 f 99aabbcc 0
rd_s3_alias3   R 00000c13 00000000 f ddeeff00 0
wr_s0_alias    W 00000022 cafef00d f 00000000 0
rd_s0_alias    R 00000020 00000000 f cafef00d 0
rd_s0_alias_b  R 00000023 00000000 f cafef00d 0
# partial byte enables
wr_s1_base     W 00000440 a5a5a5a5 f 00000000 0
wr_s1_be1      W 00000440 11111111 1 00000000 0
rd_s1_be1      R 00000440 00000000 f a5a5a511 0
wr_s1_be6      W 00000440 22222222 6 00000000 0
rd_s1_be6      R 00000440 00000000 f a5222211 0
wr_s1_be8      W 00000440 33333333 8 00000000 0
rd_s1_be8      R 00000440 00000000 f 33222211 0
wr_s1_be0      W 00000440 44444444 0 00000000 0
rd_s1_be0      R 00000440 00000000 f 33222211 0
wr_s2_base     W 000008fc 00000000 f 00000000 0
wr_s2_be5      W 000008fc ffffffff 5 00000000 0
rd_s2_be5      R 000008fc 00000000 f 00ff00ff 0
wr_s2_bea      W 000008fc 12345678 a 00000000 0
rd_s2_bea      R 000008fc 00000000 f 12ff56ff 0
wr_s3_top      W 00000ffc 0badc0de f 00000000 0
rd_s3_top      R 00000ffc 00000000 f 0badc0de 0
wr_s0_low      W 00000000 fedcba98 f 00000000 0
rd_s0_low      R 00000000 00000000 f fedcba98 0
# unmapped addresses, then the aliased word is unchanged
err_w_1000     W 00001000 deadbeef f 00000000 1
rd_s0_low_chk  R 00000000 00000000 f fedcba98 0
err_w_1010     W 00001010 deadbeef f 00000000 1
rd_s0_w4_chk   R 00000010 00000000 f 11223344 0
err_w_8000     W 80000410 deadbeef f 00000000 1
rd_s1_w4_chk   R 00000410 00000000 f 55667788 0
err_r_fffc     R fffffffc 00000000 f 00000000 1
err_r_2c10     R 00002c10 00000000 f 00000000 1
rd_s3_w4_chk   R 00000c10 00000000 f ddeeff00 0
err_w_4440     W 00004440 deadbeef f 00000000 1
rd_s1_w16_chk  R 00000440 00000000 f 33222211 0
# zero gap traffic
b2b_w0         W 00000100 01010101 f 00000000 0
b2b_w1         W 00000500 02020202 f 00000000 0
b2b_e0         W 00003000 ffffffff f 00000000 1
b2b_w2         W 00000900 03030303 f 00000000 0
b2b_w3         W 00000d00 04040404 f 00000000 0
b2b_r0         R 00000100 00000000 f 01010101 0
b2b_r1         R 00000500 00000000 f 02020202 0
b2b_e1         R 00010000 00000000 f 00000000 1
b2b_r2         R 00000900 00000000 f 03030303 0
b2b_r3         R 00000d00 00000000 f 04040404 0
b2b_w4         W 00000504 00000000 f 00000000 0
b2b_w5         W 00000506 c3c3c3c3 c 00000000 0
b2b_r4         R 00000504 00000000 f c3c30000 0
b2b_r5         R 00000c12 00000000 f ddeeff00 0
